// File: Bender.yml
package:
  name: ssb_capture

sources:
  - rtl/nr_ssb_pkg.sv
  - rtl/wb_pkg.sv
  - rtl/symbol_capture.sv
  - rtl/mem_arbiter.sv
  - rtl/symbol_ram.sv
  - rtl/host_port.sv
  - rtl/ssb_capture_top.sv
  - target: test
    files:
      - bench/mem_arbiter_sva.sv
      - bench/tb_ssb_capture.sv

// File: bench/mem_arbiter_sva.sv
`timescale 1ns/1ps

module mem_arbiter_sva (
    input logic clk_i,
    input logic reset_ni,
    input logic cap_cyc_i,
    input logic cap_stb_i,
    input logic hst_cyc_i,
    input logic hst_stb_i,
    input logic cap_ack_i,      // arbiter cap_ack_o
    input logic hst_ack_i,      // arbiter hst_ack_o
    input logic ram_stb_i,      // arbiter ram_stb_o
    input logic ram_ack_i
);

    // each memory ack reaches exactly one master
    one_ack: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ram_ack_i |-> $onehot({cap_ack_i, hst_ack_i}))
        else $error("memory ack not steered to exactly one master");

    cap_ack_to_req: assert property (@(posedge clk_i) disable iff (!reset_ni)
        cap_ack_i |-> cap_cyc_i && cap_stb_i)
        else $error("capture acked without a pending request");

    hst_ack_to_req: assert property (@(posedge clk_i) disable iff (!reset_ni)
        hst_ack_i |-> hst_cyc_i && hst_stb_i)
        else $error("host acked without a pending request");

    // memory strobe holds until the memory answers
    ram_stb_held: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ram_stb_i && !ram_ack_i |=> ram_stb_i)
        else $error("memory strobe dropped before ack");

endmodule

bind mem_arbiter mem_arbiter_sva u_mem_arbiter_sva (
    .clk_i     (clk_i),
    .reset_ni  (reset_ni),
    .cap_cyc_i (cap_cyc_i),
    .cap_stb_i (cap_stb_i),
    .hst_cyc_i (hst_cyc_i),
    .hst_stb_i (hst_stb_i),
    .cap_ack_i (cap_ack_o),
    .hst_ack_i (hst_ack_o),
    .ram_stb_i (ram_stb_o),
    .ram_ack_i (ram_ack_i)
);

// File: bench/tb_ssb_capture.sv
`timescale 1ns/1ps

module tb_ssb_capture
    import nr_ssb_pkg::*;
    import wb_pkg::*;
();

    localparam logic [31:0] SEED = 32'h933b_8077;
    localparam int BLOCK_SAMPLES = (CP_LEN - CP_ADVANCE) + SSB_SYMBOLS * FFT_LEN
                                   + (SSB_SYMBOLS - 1) * CP_LEN;
    localparam int MAX_SPACING = 6;     // clocks between valid strobes
    localparam int READ_CYCLES = 8;     // worst host read, lost arbitration included
    // three blocks, two full readbacks, margin for reset and polling
    localparam int TIMEOUT_CYCLES = 3 * BLOCK_SAMPLES * MAX_SPACING
                                    + 2 * (SAMPLE_WORDS + 2) * READ_CYCLES + 2000;
    localparam int BURST_FIRST = 100;   // inside the symbol 0 body
    localparam int BURST_LEN   = 8;

    logic                clk_i;
    logic                reset_ni;
    logic [SAMPLE_W-1:0] sample_i;
    logic                sample_valid_i;
    logic                ssb_start_i;
    logic                wb_cyc_i;
    logic                wb_stb_i;
    logic                wb_we_i;
    logic [WB_ADR_W-1:0] wb_adr_i;
    logic                wb_ack_o;
    logic [WB_DAT_W-1:0] wb_dat_o;
    logic                symbol_start_o;
    logic                pbch_start_o;
    logic                sss_start_o;

    logic [SAMPLE_W-1:0] sent_q[$];     // samples sent since the last start
    logic [WB_ADR_W-1:0] rd_adr_q[$];
    logic [WB_DAT_W-1:0] rd_dat_q[$];
    logic [WB_ADR_W-1:0] cmp_adr;
    logic [WB_DAT_W-1:0] cmp_dat;
    logic                exp_ovf;       // status the compare process expects
    logic                exp_busy;
    logic                exp_done;
    logic [2:0]          exp_stored;
    logic [WB_DAT_W-1:0] rd;
    int unsigned         cycle_cnt;
    int                  err_cnt;
    int                  chk_cnt;
    int                  test_cnt;
    int                  test_err;
    int                  sym_cnt;
    int                  cont_reads;
    bit                  sending;

    ssb_capture_top DUT (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .ssb_start_i    (ssb_start_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_ack_o       (wb_ack_o),
        .wb_dat_o       (wb_dat_o),
        .symbol_start_o (symbol_start_o),
        .pbch_start_o   (pbch_start_o),
        .sss_start_o    (sss_start_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    // host word from the sample log and the status rules
    function automatic logic [31:0] expected_word(input logic [WB_ADR_W-1:0] adr);
        logic [31:0] word;
        int          idx;
        word = '0;
        if (int'(adr) == STATUS_ADR) begin
            word = {26'b0, exp_ovf, exp_busy, exp_done, exp_stored};
        end else if (int'(adr) < SAMPLE_WORDS) begin
            // first prefix shortened by the timing advance
            idx = (CP_LEN - CP_ADVANCE) + (int'(adr) / FFT_LEN) * (FFT_LEN + CP_LEN)
                  + int'(adr) % FFT_LEN;
            if (idx < sent_q.size()) begin
                word = sent_q[idx];
            end
        end
        return word;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        $display("test %-10s %s", name, (err_cnt == test_err) ? "pass" : "fail");
        test_err = err_cnt;
    endtask

    task automatic set_status(input logic ovf, input logic busy, input logic done,
                              input logic [2:0] stored);
        exp_ovf    = ovf;
        exp_busy   = busy;
        exp_done   = done;
        exp_stored = stored;
    endtask

    // one classic read; cmp queues the result for the compare process
    task automatic host_read(input logic [WB_ADR_W-1:0] adr, input bit cmp,
                             output logic [WB_DAT_W-1:0] data);
        @(negedge clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        do @(negedge clk_i); while (!wb_ack_o);
        data     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        if (cmp) begin
            rd_adr_q.push_back(adr);
            rd_dat_q.push_back(data);
        end
    endtask

    task automatic drain();
        while (rd_adr_q.size() != 0) @(negedge clk_i);
    endtask

    task automatic start_block();
        @(negedge clk_i);
        ssb_start_i = 1'b1;
        sent_q.delete();
        sym_cnt = 0;
        @(negedge clk_i);
        ssb_start_i = 1'b0;
    endtask

    task automatic send_block(input bit burst);
        for (int i = 0; i < BLOCK_SAMPLES; i++) begin
            sample_i       = $urandom;
            sample_valid_i = 1'b1;
            sent_q.push_back(sample_i);
            @(negedge clk_i);
            if (!(burst && i >= BURST_FIRST && i < BURST_FIRST + BURST_LEN)) begin
                sample_valid_i = 1'b0;
                repeat (4 + $urandom % 2) @(negedge clk_i);    // spacing 5 or 6
            end
        end
        sample_valid_i = 1'b0;
    endtask

    task automatic wait_done();
        host_word_u word;
        word = '0;
        while (!word.status.done) begin
            host_read(WB_ADR_W'(STATUS_ADR), 1'b0, word);
        end
    endtask

    // only symbols already stored are compared
    task automatic read_during_capture();
        host_word_u word;
        int         span;
        while (sending) begin
            repeat (20 + $urandom % 40) @(negedge clk_i);
            host_read(WB_ADR_W'(STATUS_ADR), 1'b0, word);
            span = word.status.symbols_stored * FFT_LEN;
            if (span > 0) begin
                host_read(WB_ADR_W'($urandom % span), 1'b1, word);
                cont_reads++;
            end
        end
    endtask

    task automatic read_all();
        host_read(WB_ADR_W'(STATUS_ADR), 1'b1, rd);
        for (int a = 0; a < SAMPLE_WORDS; a++) begin
            host_read(WB_ADR_W'(a), 1'b1, rd);
        end
        host_read(WB_ADR_W'(800), 1'b1, rd);    // empty window
    endtask

    always @(posedge clk_i) begin
        while (rd_adr_q.size() > 0) begin
            cmp_adr = rd_adr_q.pop_front();
            cmp_dat = rd_dat_q.pop_front();
            check("wb_dat_o", cmp_dat, expected_word(cmp_adr));
        end
    end

    // pbch on symbols 0 and 2, sss on symbol 1
    always @(negedge clk_i) begin
        if (reset_ni) begin
            if (symbol_start_o) begin
                check("pbch_start_o", pbch_start_o, sym_cnt != SSS_SYMBOL);
                check("sss_start_o", sss_start_o, sym_cnt == SSS_SYMBOL);
                sym_cnt++;
            end else if (pbch_start_o || sss_start_o) begin
                err_cnt++;
                $display("a pbch or sss marker pulsed without symbol_start_o");
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        reset_ni       = 1'b0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        ssb_start_i    = 1'b0;
        wb_cyc_i       = 1'b0;
        wb_stb_i       = 1'b0;
        wb_we_i        = 1'b0;
        wb_adr_i       = '0;
        err_cnt        = 0;
        chk_cnt        = 0;
        test_cnt       = 0;
        test_err       = 0;
        sym_cnt        = 0;
        cont_reads     = 0;
        sending        = 1'b0;
        set_status(1'b0, 1'b0, 1'b0, 3'd0);
        repeat (4) @(negedge clk_i);
        reset_ni = 1'b1;

        @(negedge clk_i);
        check("wb_ack_o", wb_ack_o, 1'b0);
        check("symbol_start_o", symbol_start_o, 1'b0);
        check("pbch_start_o", pbch_start_o, 1'b0);
        check("sss_start_o", sss_start_o, 1'b0);
        host_read(WB_ADR_W'(STATUS_ADR), 1'b1, rd);
        drain();
        end_test("reset");

        start_block();
        sending = 1'b1;
        fork
            begin
                send_block(1'b0);
                sending = 1'b0;
            end
            read_during_capture();
        join
        wait_done();
        drain();
        check("symbol_start_o pulses", sym_cnt, SSB_SYMBOLS);
        end_test("markers");
        if (cont_reads == 0) begin
            err_cnt++;
            $display("no sample read was issued while capture was running");
        end
        set_status(1'b0, 1'b0, 1'b1, 3'd3);     // no overflow at legal spacing
        host_read(WB_ADR_W'(STATUS_ADR), 1'b1, rd);
        drain();
        end_test("contention");
        read_all();
        drain();
        end_test("readback");

        start_block();
        send_block(1'b1);
        wait_done();
        set_status(1'b1, 1'b0, 1'b1, 3'd3);
        host_read(WB_ADR_W'(STATUS_ADR), 1'b1, rd);
        drain();
        end_test("overflow");

        start_block();
        set_status(1'b0, 1'b1, 1'b0, 3'd0);     // cleared, waiting for samples
        host_read(WB_ADR_W'(STATUS_ADR), 1'b1, rd);
        send_block(1'b0);
        wait_done();
        drain();
        check("symbol_start_o pulses", sym_cnt, SSB_SYMBOLS);
        set_status(1'b0, 1'b0, 1'b1, 3'd3);
        read_all();
        drain();
        end_test("rearm");

        $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: rtl/host_port.sv
`timescale 1ns/1ps

module host_port
    import wb_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [WB_ADR_W-1:0]  wb_adr_i,
    input  logic                 busy_i,
    input  logic                 done_i,
    input  logic                 overflow_i,
    input  logic [2:0]           symbols_stored_i,
    input  logic                 hst_ack_i,
    input  logic [WB_DAT_W-1:0]  hst_dat_i,
    output logic                 wb_ack_o,
    output logic [WB_DAT_W-1:0]  wb_dat_o,
    output logic                 hst_cyc_o,
    output logic                 hst_stb_o,
    output logic [RAM_ADR_W-1:0] hst_adr_o
);

    logic       pend;           // request taken, ack not yet given
    logic       local_rd;       // answered here, no memory access
    logic       req;
    logic       is_sample;
    logic       is_status;
    host_word_u status_word;
    host_word_u rd_word;

    assign req       = wb_cyc_i && wb_stb_i && !pend && !wb_ack_o;
    assign is_sample = !wb_we_i && wb_adr_i < WB_ADR_W'(SAMPLE_WORDS);
    assign is_status = !wb_we_i && wb_adr_i == WB_ADR_W'(STATUS_ADR);

    always_comb begin
        status_word = '0;
        status_word.status.overflow       = overflow_i;
        status_word.status.busy           = busy_i;
        status_word.status.done           = done_i;
        status_word.status.symbols_stored = symbols_stored_i;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pend      <= 1'b0;
            local_rd  <= 1'b0;
            hst_stb_o <= 1'b0;
            wb_ack_o  <= 1'b0;
        end else begin
            wb_ack_o <= local_rd || (hst_stb_o && hst_ack_i);
            local_rd <= req && !is_sample;   // status, empty window or write
            if (req && is_sample) begin
                hst_stb_o <= 1'b1;
            end else if (hst_ack_i) begin
                hst_stb_o <= 1'b0;
            end
            if (req) begin
                pend <= 1'b1;
            end else if (wb_ack_o) begin
                pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            hst_adr_o <= wb_adr_i[RAM_ADR_W-1:0];
            rd_word   <= is_status ? status_word : '0;
        end else if (hst_ack_i) begin
            rd_word.iq.im <= hst_dat_i[WB_DAT_W-1:WB_DAT_W/2];
            rd_word.iq.re <= hst_dat_i[WB_DAT_W/2-1:0];
        end
    end

    assign wb_dat_o  = rd_word;
    assign hst_cyc_o = hst_stb_o;

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
    import wb_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic                 cap_cyc_i,
    input  logic                 cap_stb_i,
    input  logic [WB_ADR_W-1:0]  cap_adr_i,
    input  logic [WB_DAT_W-1:0]  cap_dat_i,
    input  logic                 hst_cyc_i,
    input  logic                 hst_stb_i,
    input  logic [RAM_ADR_W-1:0] hst_adr_i,
    input  logic                 ram_ack_i,
    input  logic [WB_DAT_W-1:0]  ram_dat_i,
    output logic                 cap_ack_o,
    output logic                 hst_ack_o,
    output logic [WB_DAT_W-1:0]  hst_dat_o,
    output logic                 ram_cyc_o,
    output logic                 ram_stb_o,
    output logic                 ram_we_o,
    output logic [RAM_ADR_W-1:0] ram_adr_o,
    output logic [WB_DAT_W-1:0]  ram_dat_o
);

    logic active;       // a grant is held
    logic owner_hst;    // 0: capture, 1: host
    logic cap_req;
    logic hst_req;

    assign cap_req = cap_cyc_i && cap_stb_i;
    assign hst_req = hst_cyc_i && hst_stb_i;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            active    <= 1'b0;
            owner_hst <= 1'b0;
        end else if (!active) begin
            if (cap_req) begin
                active    <= 1'b1;
                owner_hst <= 1'b0;          // capture wins a tie
            end else if (hst_req) begin
                active    <= 1'b1;
                owner_hst <= 1'b1;
            end
        end else if (ram_ack_i) begin
            // pass straight to a waiting master, else release
            if (owner_hst ? cap_req : hst_req) begin
                owner_hst <= !owner_hst;
            end else begin
                active <= 1'b0;
            end
        end
    end

    assign ram_cyc_o = active && (owner_hst ? hst_cyc_i : cap_cyc_i);
    assign ram_stb_o = active && (owner_hst ? hst_stb_i : cap_stb_i);
    assign ram_we_o  = active && !owner_hst;    // capture only writes
    assign ram_adr_o = owner_hst ? hst_adr_i : cap_adr_i[RAM_ADR_W-1:0];
    assign ram_dat_o = cap_dat_i;

    assign cap_ack_o = active && !owner_hst && ram_ack_i;
    assign hst_ack_o = active && owner_hst && ram_ack_i;
    assign hst_dat_o = ram_dat_i;

endmodule

// File: rtl/nr_ssb_pkg.sv
package nr_ssb_pkg;

    // SSB numerology, 256-point symbols
    localparam int FFT_LEN     = 256;   // body samples per symbol
    localparam int CP_LEN      = 18;    // normal cyclic prefix
    localparam int CP_ADVANCE  = 9;     // timing advance into first prefix
    localparam int SSB_SYMBOLS = 3;     // PBCH, SSS, PBCH
    localparam int SSS_SYMBOL  = 1;     // index of the SSS symbol in the block

    localparam int SYM_IDX_W = 2;
    localparam int SAMPLE_W  = 32;      // im in upper half, re in lower

    // counter widths
    localparam int BODY_CNT_W = $clog2(FFT_LEN);
    localparam int CP_CNT_W   = $clog2(CP_LEN);

endpackage

// File: rtl/ssb_capture_top.sv
`timescale 1ns/1ps

module ssb_capture_top
    import nr_ssb_pkg::*;
    import wb_pkg::*;
(
    input  logic                clk_i,
    input  logic                reset_ni,
    input  logic [SAMPLE_W-1:0] sample_i,
    input  logic                sample_valid_i,
    input  logic                ssb_start_i,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [WB_ADR_W-1:0] wb_adr_i,
    output logic                wb_ack_o,
    output logic [WB_DAT_W-1:0] wb_dat_o,
    output logic                symbol_start_o,
    output logic                pbch_start_o,
    output logic                sss_start_o
);

    // capture master
    logic                 cap_cyc;
    logic                 cap_stb;
    logic                 cap_ack;
    logic [WB_ADR_W-1:0]  cap_adr;
    logic [WB_DAT_W-1:0]  cap_dat;
    // host master
    logic                 hst_cyc;
    logic                 hst_stb;
    logic                 hst_ack;
    logic [RAM_ADR_W-1:0] hst_adr;
    logic [WB_DAT_W-1:0]  hst_dat;
    // memory side
    logic                 ram_cyc;
    logic                 ram_stb;
    logic                 ram_we;
    logic                 ram_ack;
    logic [RAM_ADR_W-1:0] ram_adr;
    logic [WB_DAT_W-1:0]  ram_wdat;
    logic [WB_DAT_W-1:0]  ram_rdat;
    // status
    logic                 busy;
    logic                 done;
    logic                 overflow;
    logic [2:0]           symbols_stored;

    symbol_capture u_symbol_capture (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .sample_i         (sample_i),
        .sample_valid_i   (sample_valid_i),
        .ssb_start_i      (ssb_start_i),
        .cap_ack_i        (cap_ack),
        .cap_cyc_o        (cap_cyc),
        .cap_stb_o        (cap_stb),
        .cap_adr_o        (cap_adr),
        .cap_dat_o        (cap_dat),
        .symbol_start_o   (symbol_start_o),
        .pbch_start_o     (pbch_start_o),
        .sss_start_o      (sss_start_o),
        .busy_o           (busy),
        .done_o           (done),
        .overflow_o       (overflow),
        .symbols_stored_o (symbols_stored)
    );

    host_port u_host_port (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .wb_cyc_i         (wb_cyc_i),
        .wb_stb_i         (wb_stb_i),
        .wb_we_i          (wb_we_i),
        .wb_adr_i         (wb_adr_i),
        .busy_i           (busy),
        .done_i           (done),
        .overflow_i       (overflow),
        .symbols_stored_i (symbols_stored),
        .hst_ack_i        (hst_ack),
        .hst_dat_i        (hst_dat),
        .wb_ack_o         (wb_ack_o),
        .wb_dat_o         (wb_dat_o),
        .hst_cyc_o        (hst_cyc),
        .hst_stb_o        (hst_stb),
        .hst_adr_o        (hst_adr)
    );

    mem_arbiter u_mem_arbiter (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .cap_cyc_i (cap_cyc),
        .cap_stb_i (cap_stb),
        .cap_adr_i (cap_adr),
        .cap_dat_i (cap_dat),
        .hst_cyc_i (hst_cyc),
        .hst_stb_i (hst_stb),
        .hst_adr_i (hst_adr),
        .ram_ack_i (ram_ack),
        .ram_dat_i (ram_rdat),
        .cap_ack_o (cap_ack),
        .hst_ack_o (hst_ack),
        .hst_dat_o (hst_dat),
        .ram_cyc_o (ram_cyc),
        .ram_stb_o (ram_stb),
        .ram_we_o  (ram_we),
        .ram_adr_o (ram_adr),
        .ram_dat_o (ram_wdat)
    );

    symbol_ram u_symbol_ram (
        .clk_i     (clk_i),
        .ram_cyc_i (ram_cyc),
        .ram_stb_i (ram_stb),
        .ram_we_i  (ram_we),
        .ram_adr_i (ram_adr),
        .ram_dat_i (ram_wdat),
        .ram_ack_o (ram_ack),
        .ram_dat_o (ram_rdat)
    );

endmodule

// File: rtl/symbol_capture.sv
`timescale 1ns/1ps

module symbol_capture
    import nr_ssb_pkg::*;
    import wb_pkg::*;
(
    input  logic                clk_i,
    input  logic                reset_ni,
    input  logic [SAMPLE_W-1:0] sample_i,
    input  logic                sample_valid_i,
    input  logic                ssb_start_i,
    input  logic                cap_ack_i,
    output logic                cap_cyc_o,
    output logic                cap_stb_o,
    output logic [WB_ADR_W-1:0] cap_adr_o,
    output logic [WB_DAT_W-1:0] cap_dat_o,
    output logic                symbol_start_o,
    output logic                pbch_start_o,
    output logic                sss_start_o,
    output logic                busy_o,
    output logic                done_o,
    output logic                overflow_o,
    output logic [2:0]          symbols_stored_o
);

    logic                  active;      // block capture running
    logic                  in_body;     // low while skipping a prefix
    logic [CP_CNT_W-1:0]   cp_cnt;
    logic [BODY_CNT_W-1:0] body_cnt;
    logic [SYM_IDX_W-1:0]  sym_idx;
    logic                  pend_last;   // pending write closes a symbol body
    logic                  start;
    logic                  take;
    logic                  drop;
    logic                  last_body;
    logic                  first_body;
    logic                  sym_end;

    assign start      = ssb_start_i && !busy_o;
    assign take       = active && in_body && sample_valid_i;
    assign drop       = take && cap_stb_o;      // previous write not yet acked
    assign last_body  = body_cnt == BODY_CNT_W'(FFT_LEN - 1);
    assign first_body = body_cnt == '0;
    assign sym_end    = cap_ack_i && (pend_last || (drop && last_body));

    assign busy_o    = active || cap_stb_o;
    assign cap_cyc_o = cap_stb_o;

    // framing: prefix skip, then body
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            active   <= 1'b0;
            in_body  <= 1'b0;
            cp_cnt   <= '0;
            body_cnt <= '0;
            sym_idx  <= '0;
        end else if (start) begin
            active   <= 1'b1;
            in_body  <= 1'b0;
            cp_cnt   <= CP_CNT_W'(CP_ADVANCE);  // first prefix is shorter
            body_cnt <= '0;
            sym_idx  <= '0;
        end else if (active && sample_valid_i) begin
            if (!in_body) begin
                if (cp_cnt == CP_CNT_W'(CP_LEN - 1)) begin
                    in_body <= 1'b1;
                end
                cp_cnt <= cp_cnt + 1'b1;
            end else begin
                body_cnt <= body_cnt + 1'b1;    // advances on drops too
                if (last_body) begin
                    in_body <= 1'b0;
                    cp_cnt  <= '0;
                    if (sym_idx == SYM_IDX_W'(SSB_SYMBOLS - 1)) begin
                        active <= 1'b0;
                    end else begin
                        sym_idx <= sym_idx + 1'b1;
                    end
                end
            end
        end
    end

    // write master handshake and sticky overflow
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cap_stb_o  <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            if (start) begin
                overflow_o <= 1'b0;
            end else if (drop) begin
                overflow_o <= 1'b1;
            end
            if (take && !cap_stb_o) begin
                cap_stb_o <= 1'b1;
            end else if (cap_ack_i) begin
                cap_stb_o <= 1'b0;
            end
        end
    end

    // pending write word
    always_ff @(posedge clk_i) begin
        if (take && !cap_stb_o) begin
            cap_adr_o <= WB_ADR_W'({sym_idx, body_cnt});
            cap_dat_o <= sample_i;
            pend_last <= last_body;
        end else if (drop && last_body && !cap_ack_i) begin
            pend_last <= 1'b1;          // lost final sample, symbol ends with this write
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            symbols_stored_o <= '0;
            done_o           <= 1'b0;
        end else if (start) begin
            symbols_stored_o <= '0;
            done_o           <= 1'b0;
        end else if (sym_end) begin
            symbols_stored_o <= symbols_stored_o + 1'b1;
            done_o           <= symbols_stored_o == 3'(SSB_SYMBOLS - 1);
        end
    end

    // markers, one clock after body sample 0
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            symbol_start_o <= 1'b0;
            pbch_start_o   <= 1'b0;
            sss_start_o    <= 1'b0;
        end else begin
            symbol_start_o <= take && first_body;
            pbch_start_o   <= take && first_body && sym_idx != SYM_IDX_W'(SSS_SYMBOL);
            sss_start_o    <= take && first_body && sym_idx == SYM_IDX_W'(SSS_SYMBOL);
        end
    end

endmodule

// File: rtl/symbol_ram.sv
`timescale 1ns/1ps

module symbol_ram
    import wb_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 ram_cyc_i,
    input  logic                 ram_stb_i,
    input  logic                 ram_we_i,
    input  logic [RAM_ADR_W-1:0] ram_adr_i,
    input  logic [WB_DAT_W-1:0]  ram_dat_i,
    output logic                 ram_ack_o,
    output logic [WB_DAT_W-1:0]  ram_dat_o
);

    logic [WB_DAT_W-1:0] mem [RAM_DEPTH];
    logic                req;

    assign req = ram_cyc_i && ram_stb_i;

    always_ff @(posedge clk_i) begin
        if (req && ram_we_i && !ram_ack_o) begin
            mem[ram_adr_i] <= ram_dat_i;    // once per access
        end
        ram_dat_o <= mem[ram_adr_i];
    end

    // single-cycle ack, low again when stb falls or after each ack
    always_ff @(posedge clk_i) begin
        ram_ack_o <= req && !ram_ack_o;
    end

endmodule

// File: rtl/wb_pkg.sv
package wb_pkg;

    localparam int WB_ADR_W = 11;       // word address
    localparam int WB_DAT_W = 32;

    localparam int RAM_DEPTH = 1024;
    localparam int RAM_ADR_W = $clog2(RAM_DEPTH);

    // host map: samples at 0..767, status at 1024, zero elsewhere
    localparam int SAMPLE_WORDS = 768;
    localparam int STATUS_ADR   = 1024;

    // host read word, either a stored sample or the status register
    typedef union packed {
        struct packed {
            logic [15:0] im;
            logic [15:0] re;
        } iq;
        struct packed {
            logic [25:0] reserved;
            logic        overflow;
            logic        busy;
            logic        done;
            logic [2:0]  symbols_stored;
        } status;
    } host_word_u;

endpackage

// File: vlog.f
rtl/nr_ssb_pkg.sv
rtl/wb_pkg.sv
rtl/symbol_capture.sv
rtl/mem_arbiter.sv
rtl/symbol_ram.sv
rtl/host_port.sv
rtl/ssb_capture_top.sv
bench/mem_arbiter_sva.sv
bench/tb_ssb_capture.sv
